// ==== src/cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Byte address width of the requester and memory ports
`define CACHE_ADDR_WIDTH 32

// Address split into tag, set index and byte offset
`define CACHE_OFFSET_BITS 5
`define CACHE_INDEX_BITS 3
`define CACHE_TAG_BITS (`CACHE_ADDR_WIDTH - `CACHE_OFFSET_BITS - `CACHE_INDEX_BITS)

// One line is 32 bytes and moves as a whole
`define CACHE_LINE_BITS 256

// Associativity assumed by the pseudo-LRU tree
`define CACHE_WAYS 4

`endif

// ==== src/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // Controller states
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FILL
    } cache_state_t;

    // Request held by the controller while it is served
    typedef enum logic [1:0] {
        OP_NONE,
        OP_READ,
        OP_WRITE
    } cache_op_t;

endpackage

`default_nettype wire

// ==== src/lru_tree.sv ====
`default_nettype none

`include "cache_config.svh"

module lru_tree (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         read,
    input  logic                         load,
    input  logic [`CACHE_INDEX_BITS-1:0] rindex,
    input  logic [`CACHE_INDEX_BITS-1:0] windex,
    input  logic [`CACHE_WAYS-1:0]       hits,
    output logic [`CACHE_WAYS-1:0]       way
);

    localparam int NUM_SETS = 1 << `CACHE_INDEX_BITS;

    // Bit 0 is the root, bit 1 picks within ways 0/1, bit 2 within ways 2/3
    logic [2:0] tree_mem [NUM_SETS];
    logic [2:0] tree_q;
    logic [2:0] tree_next;
    logic [1:0] victim_idx;
    logic [1:0] way_idx;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                tree_mem[s] <= '0;
            end
            tree_q <= '0;
        end else begin
            if (read) begin
                tree_q <= tree_mem[rindex];
            end
            if (load) begin
                tree_mem[windex] <= tree_next;
            end
        end
    end

    // Tree bits point at the victim
    assign victim_idx = tree_q[0] ? {1'b1, tree_q[2]} : {1'b0, tree_q[1]};

    always_comb begin
        way_idx = victim_idx;
        way     = '0;
        if (|hits) begin
            way = hits;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (hits[w]) begin
                    way_idx = 2'(w);
                end
            end
        end else begin
            way[victim_idx] = 1'b1;
        end
    end

    // Point the path away from the way just used
    always_comb begin
        tree_next    = tree_q;
        tree_next[0] = ~way_idx[1];
        if (way_idx[1]) begin
            tree_next[2] = ~way_idx[0];
        end else begin
            tree_next[1] = ~way_idx[0];
        end
    end

endmodule

`default_nettype wire

// ==== src/cache_store.sv ====
`default_nettype none

`include "cache_config.svh"

module cache_store (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         read,
    input  logic                         load,
    input  logic [`CACHE_INDEX_BITS-1:0] rindex,
    input  logic [`CACHE_INDEX_BITS-1:0] windex,
    input  logic [`CACHE_TAG_BITS-1:0]   tag_in,
    input  logic                         dirty_in,
    input  logic [`CACHE_LINE_BITS-1:0] line_in,
    output logic                         valid,
    output logic                         dirty,
    output logic [`CACHE_TAG_BITS-1:0]   tag,
    output logic [`CACHE_LINE_BITS-1:0] line
);

    localparam int NUM_SETS = 1 << `CACHE_INDEX_BITS;

    logic                        valid_mem [NUM_SETS];
    logic                        dirty_mem [NUM_SETS];
    logic [`CACHE_TAG_BITS-1:0]  tag_mem   [NUM_SETS];
    logic [`CACHE_LINE_BITS-1:0] line_mem  [NUM_SETS];

    // Valid bits
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_mem[s] <= 1'b0;
            end
            valid <= 1'b0;
        end else begin
            if (read) begin
                valid <= valid_mem[rindex];
            end
            if (load) begin
                valid_mem[windex] <= 1'b1;
            end
        end
    end

    // Dirty, tag and data
    always_ff @(posedge clk) begin
        if (read) begin
            dirty <= dirty_mem[rindex];
            tag   <= tag_mem[rindex];
            line  <= line_mem[rindex];
        end
        if (load) begin
            dirty_mem[windex] <= dirty_in;
            tag_mem[windex]   <= tag_in;
            line_mem[windex]  <= line_in;
        end
    end

endmodule

`default_nettype wire

// ==== src/cache_datapath.sv ====
`default_nettype none

`include "cache_config.svh"

module cache_datapath
    import cache_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`CACHE_ADDR_WIDTH-1:0] mem_address,
    input  logic [`CACHE_LINE_BITS-1:0]  mem_wdata,
    input  logic [`CACHE_LINE_BITS-1:0]  pmem_rdata,
    input  logic                         pmem_resp,
    input  logic                         array_read,
    input  logic                         ld_wb,
    input  logic                         load_line,
    input  logic                         new_dirty,
    input  logic                         addr_sel,
    input  cache_op_t                    op,
    output logic                         hit,
    output logic                         victim_dirty,
    output logic [`CACHE_LINE_BITS-1:0]  mem_rdata,
    output logic [`CACHE_ADDR_WIDTH-1:0] pmem_address,
    output logic [`CACHE_LINE_BITS-1:0]  pmem_wdata
);

    localparam int IDX_LSB = `CACHE_OFFSET_BITS;
    localparam int TAG_LSB = `CACHE_OFFSET_BITS + `CACHE_INDEX_BITS;

    logic [`CACHE_ADDR_WIDTH-1:0] req_addr;
    logic [`CACHE_TAG_BITS-1:0]   req_tag;
    logic [`CACHE_INDEX_BITS-1:0] req_index;
    logic [`CACHE_INDEX_BITS-1:0] rindex;

    logic [`CACHE_WAYS-1:0]       valids;
    logic [`CACHE_WAYS-1:0]       dirtys;
    logic [`CACHE_WAYS-1:0]       hits;
    logic [`CACHE_WAYS-1:0]       way;
    logic [`CACHE_TAG_BITS-1:0]   tags  [`CACHE_WAYS];
    logic [`CACHE_LINE_BITS-1:0]  lines [`CACHE_WAYS];

    logic                         sel_valid;
    logic                         sel_dirty;
    logic [`CACHE_TAG_BITS-1:0]   sel_tag;
    logic [`CACHE_LINE_BITS-1:0]  sel_line;
    logic [`CACHE_LINE_BITS-1:0]  line_in;

    logic [`CACHE_ADDR_WIDTH-1:0] wb_addr;
    logic [`CACHE_LINE_BITS-1:0]  wb_line;

    // Request address held for the whole transaction
    always_ff @(posedge clk) begin
        if (array_read) begin
            req_addr <= mem_address;
        end
    end

    assign req_tag   = req_addr[`CACHE_ADDR_WIDTH-1:TAG_LSB];
    assign req_index = req_addr[TAG_LSB-1:IDX_LSB];
    assign rindex    = mem_address[TAG_LSB-1:IDX_LSB];

    // Whole-line write from the requester, else a fill, else rewrite on a read hit
    assign line_in = (op == OP_WRITE) ? mem_wdata :
                     hit              ? sel_line  : pmem_rdata;

    for (genvar i = 0; i < `CACHE_WAYS; i++) begin : g_way
        cache_store store_i (
            .clk      (clk),
            .reset    (reset),
            .read     (array_read),
            .load     (load_line & way[i]),
            .rindex   (rindex),
            .windex   (req_index),
            .tag_in   (req_tag),
            .dirty_in (new_dirty),
            .line_in  (line_in),
            .valid    (valids[i]),
            .dirty    (dirtys[i]),
            .tag      (tags[i]),
            .line     (lines[i])
        );

        assign hits[i] = valids[i] & (tags[i] == req_tag);
    end

    assign hit = |hits;

    lru_tree lru_i (
        .clk    (clk),
        .reset  (reset),
        .read   (array_read),
        .load   (load_line),
        .rindex (rindex),
        .windex (req_index),
        .hits   (hits),
        .way    (way)
    );

    // One-hot way mux
    always_comb begin
        sel_valid = 1'b0;
        sel_dirty = 1'b0;
        sel_tag   = '0;
        sel_line  = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (way[w]) begin
                sel_valid = sel_valid | valids[w];
                sel_dirty = sel_dirty | dirtys[w];
                sel_tag   = sel_tag | tags[w];
                sel_line  = sel_line | lines[w];
            end
        end
    end

    // Invalid ways never need a write-back
    assign victim_dirty = sel_valid & sel_dirty;

    always_ff @(posedge clk) begin
        if (ld_wb) begin
            wb_line <= sel_line;
            wb_addr <= {sel_tag, req_index, {`CACHE_OFFSET_BITS{1'b0}}};
        end
    end

    assign pmem_address = addr_sel ? wb_addr
                                   : {req_tag, req_index, {`CACHE_OFFSET_BITS{1'b0}}};
    assign pmem_wdata   = wb_line;
    assign mem_rdata    = pmem_resp ? pmem_rdata : sel_line;

endmodule

`default_nettype wire

// ==== src/cache_control.sv ====
`default_nettype none

module cache_control
    import cache_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      mem_read,
    input  logic      mem_write,
    input  logic      pmem_resp,
    input  logic      hit,
    input  logic      victim_dirty,
    output logic      mem_resp,
    output logic      pmem_read,
    output logic      pmem_write,
    output logic      array_read,
    output logic      ld_wb,
    output logic      load_line,
    output logic      new_dirty,
    output logic      addr_sel,
    output cache_op_t op
);

    cache_state_t state;
    cache_state_t state_next;
    cache_op_t    op_q;
    logic         request;

    assign request = mem_read | mem_write;
    assign op      = op_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            op_q  <= OP_NONE;
        end else begin
            state <= state_next;
            if (state == IDLE) begin
                if (request) begin
                    op_q <= mem_write ? OP_WRITE : OP_READ;
                end else begin
                    op_q <= OP_NONE;
                end
            end
        end
    end

    always_comb begin
        state_next = state;
        mem_resp   = 1'b0;
        pmem_read  = 1'b0;
        pmem_write = 1'b0;
        array_read = 1'b0;
        ld_wb      = 1'b0;
        load_line  = 1'b0;
        new_dirty  = 1'b0;
        addr_sel   = 1'b0;

        case (state)
            IDLE: begin
                if (request) begin
                    array_read = 1'b1;
                    state_next = LOOKUP;
                end
            end

            LOOKUP: begin
                if (hit) begin
                    // A read hit keeps the line's dirty bit
                    load_line  = 1'b1;
                    new_dirty  = (op_q == OP_WRITE) | victim_dirty;
                    mem_resp   = 1'b1;
                    state_next = IDLE;
                end else begin
                    ld_wb      = 1'b1;
                    state_next = victim_dirty ? WRITEBACK : FILL;
                end
            end

            WRITEBACK: begin
                pmem_write = 1'b1;
                addr_sel   = 1'b1;
                if (pmem_resp) begin
                    state_next = FILL;
                end
            end

            FILL: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    load_line  = 1'b1;
                    new_dirty  = (op_q == OP_WRITE);
                    mem_resp   = 1'b1;
                    state_next = IDLE;
                end
            end

            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/cache_top.sv ====
`default_nettype none

`include "cache_config.svh"

module cache_top
    import cache_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         mem_read,
    input  logic                         mem_write,
    input  logic [`CACHE_ADDR_WIDTH-1:0] mem_address,
    input  logic [`CACHE_LINE_BITS-1:0]  mem_wdata,
    output logic                         mem_resp,
    output logic [`CACHE_LINE_BITS-1:0]  mem_rdata,
    input  logic                         pmem_resp,
    input  logic [`CACHE_LINE_BITS-1:0]  pmem_rdata,
    output logic                         pmem_read,
    output logic                         pmem_write,
    output logic [`CACHE_ADDR_WIDTH-1:0] pmem_address,
    output logic [`CACHE_LINE_BITS-1:0]  pmem_wdata
);

    logic      hit;
    logic      victim_dirty;
    logic      array_read;
    logic      ld_wb;
    logic      load_line;
    logic      new_dirty;
    logic      addr_sel;
    cache_op_t op;

    cache_control control_i (
        .clk          (clk),
        .reset        (reset),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .pmem_resp    (pmem_resp),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .mem_resp     (mem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .array_read   (array_read),
        .ld_wb        (ld_wb),
        .load_line    (load_line),
        .new_dirty    (new_dirty),
        .addr_sel     (addr_sel),
        .op           (op)
    );

    cache_datapath datapath_i (
        .clk          (clk),
        .reset        (reset),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp),
        .array_read   (array_read),
        .ld_wb        (ld_wb),
        .load_line    (load_line),
        .new_dirty    (new_dirty),
        .addr_sel     (addr_sel),
        .op           (op),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .mem_rdata    (mem_rdata),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata)
    );

endmodule

`default_nettype wire

// ==== testbench/clock_gen.sv ====
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset held over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== testbench/cache_tb.sv ====
`default_nettype none

`include "cache_config.svh"

module cache_tb;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int AW = `CACHE_ADDR_WIDTH;
    localparam int LW = `CACHE_LINE_BITS;

    logic          clk;
    logic          reset;
    logic          mem_read;
    logic          mem_write;
    logic [AW-1:0] mem_address;
    logic [LW-1:0] mem_wdata;
    logic          mem_resp;
    logic [LW-1:0] mem_rdata;
    logic          pmem_resp;
    logic [LW-1:0] pmem_rdata;
    logic          pmem_read;
    logic          pmem_write;
    logic [AW-1:0] pmem_address;
    logic [LW-1:0] pmem_wdata;

    int            error_count;
    int            timeout_count;
    logic [15:0]   lfsr_state;

    // Memory model contents and every access it served
    logic [AW-1:0] stored_addr [$];
    logic [LW-1:0] stored_data [$];
    logic          log_write   [$];
    logic [AW-1:0] log_addr    [$];
    logic [LW-1:0] log_data    [$];

    clock_gen clock_i (
        .clk   (clk),
        .reset (reset)
    );

    cache_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .mem_resp     (mem_resp),
        .mem_rdata    (mem_rdata),
        .pmem_resp    (pmem_resp),
        .pmem_rdata   (pmem_rdata),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata)
    );

    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value      = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic [AW-1:0] line_address(input int tag, input int set_index);
        line_address = {tag[`CACHE_TAG_BITS-1:0], set_index[`CACHE_INDEX_BITS-1:0],
                        {`CACHE_OFFSET_BITS{1'b0}}};
    endfunction

    // Untouched lines read back as their own address
    function automatic logic [LW-1:0] fetch_line(input logic [AW-1:0] addr);
        fetch_line = {8{addr}};
        foreach (stored_addr[i]) begin
            if (stored_addr[i] == addr) begin
                fetch_line = stored_data[i];
            end
        end
    endfunction

    task automatic serve_memory();
        int            delay;
        logic          is_write;
        logic [AW-1:0] addr;
        logic [LW-1:0] data;
        take_bits(2, delay);
        delay    = delay + 1;
        is_write = pmem_write;
        addr     = pmem_address;
        data     = is_write ? pmem_wdata : fetch_line(addr);
        if (is_write) begin
            stored_addr.push_back(addr);
            stored_data.push_back(data);
        end
        log_write.push_back(is_write);
        log_addr.push_back(addr);
        log_data.push_back(data);
        repeat (delay) @(posedge clk);
        #1;
        pmem_resp  = 1'b1;
        pmem_rdata = data;
        @(posedge clk);
        #1;
        pmem_resp  = 1'b0;
    endtask

    initial begin
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        lfsr_state = 16'd17728;
        forever begin
            @(negedge clk);
            if (reset === 1'b0 && (pmem_read === 1'b1 || pmem_write === 1'b1)) begin
                serve_memory();
            end
        end
    end

    task automatic report_error(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic end_run();
        $display("Value errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic clear_log();
        log_write.delete();
        log_addr.delete();
        log_data.delete();
    endtask

    // Latency counts cycles from the request cycle to the mem_resp cycle
    task automatic request_line(input logic is_write, input logic [AW-1:0] addr,
                                input logic [LW-1:0] wdata, output logic [LW-1:0] rdata,
                                output int latency);
        int cycles;
        @(posedge clk);
        #1;
        mem_read    = ~is_write;
        mem_write   = is_write;
        mem_address = addr;
        mem_wdata   = wdata;
        cycles      = 0;
        @(negedge clk);
        while (mem_resp !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        rdata   = mem_rdata;
        latency = cycles;
        if (mem_resp !== 1'b1) begin
            $display("Timeout: no mem_resp within %0d cycles for address %h, DUT state %s",
                     TIMEOUT_CYCLES, addr, dut_i.control_i.state.name());
            timeout_count++;
            end_run();
        end else begin
            @(posedge clk);
            #1;
            mem_read  = 1'b0;
            mem_write = 1'b0;
        end
    endtask

    task automatic read_expect(input logic [AW-1:0] addr, input logic [LW-1:0] exp,
                               input logic want_hit, input string what);
        logic [LW-1:0] rdata;
        int            lat;
        request_line(1'b0, addr, '0, rdata, lat);
        if (want_hit && lat != 1)
            report_error($sformatf("%s: hit answered after %0d cycles", what, lat));
        if (!want_hit && lat <= 1)
            report_error($sformatf("%s: expected a miss, answered in one cycle", what));
        if (rdata !== exp)
            report_error($sformatf("%s: read data %h, expected %h", what, rdata, exp));
    endtask

    task automatic write_expect(input logic [AW-1:0] addr, input logic [LW-1:0] data,
                                input logic want_hit, input string what);
        logic [LW-1:0] rdata;
        int            lat;
        request_line(1'b1, addr, data, rdata, lat);
        if (want_hit && lat != 1)
            report_error($sformatf("%s: hit answered after %0d cycles", what, lat));
        if (!want_hit && lat <= 1)
            report_error($sformatf("%s: expected a miss, answered in one cycle", what));
    endtask

    task automatic read_lines(input int first_tag, input int count, input int set_index,
                              input logic want_hit, input string what);
        logic [AW-1:0] addr;
        for (int t = first_tag; t < first_tag + count; t++) begin
            addr = line_address(t, set_index);
            read_expect(addr, {8{addr}}, want_hit, what);
        end
    endtask

    task automatic expect_log_size(input int n, input string what);
        if (log_addr.size() != n)
            report_error($sformatf("%s: %0d memory accesses, expected %0d",
                                   what, log_addr.size(), n));
    endtask

    task automatic expect_mem_op(input int pos, input logic is_write, input logic [AW-1:0] addr,
                                 input logic [LW-1:0] data, input string what);
        if (log_addr.size() <= pos)
            report_error($sformatf("%s: memory access %0d missing", what, pos));
        else if (log_write[pos] !== is_write || log_addr[pos] !== addr)
            report_error($sformatf("%s: access %0d was write=%0b at %h, expected write=%0b at %h",
                                   what, pos, log_write[pos], log_addr[pos], is_write, addr));
        else if (is_write && log_data[pos] !== data)
            report_error($sformatf("%s: access %0d carried %h, expected %h",
                                   what, pos, log_data[pos], data));
    endtask

    task automatic reset_and_first_miss();
        logic [AW-1:0] x;
        x = line_address('h10, 0);
        @(negedge clk);
        if (mem_resp !== 1'b0 || pmem_read !== 1'b0 || pmem_write !== 1'b0)
            report_error("mem_resp or a memory request active after reset");
        clear_log();
        read_expect(x | 32'h0C, {8{x}}, 1'b0, "first read");
        expect_log_size(1, "first read");
        expect_mem_op(0, 1'b0, x, '0, "first read");
    endtask

    task automatic repeat_read_hits();
        logic [AW-1:0] x;
        x = line_address('h10, 0);
        clear_log();
        read_expect(x | 32'h04, {8{x}}, 1'b1, "repeat read");
        expect_log_size(0, "repeat read");
    endtask

    task automatic write_hit_then_read();
        logic [AW-1:0] x;
        logic [LW-1:0] w;
        x = line_address('h10, 0);
        w = {8{32'hC0DE_0010}};
        clear_log();
        write_expect(x, w, 1'b1, "write hit");
        read_expect(x, w, 1'b1, "read after write hit");
        expect_log_size(0, "write hit and read");
    endtask

    // Victim order 0, 2, 1, 3 leaves A as the victim for E
    task automatic dirty_victim_writeback();
        logic [AW-1:0] a;
        logic [AW-1:0] e;
        logic [LW-1:0] w;
        a = line_address('h20, 1);
        e = line_address('h24, 1);
        w = {8{32'hDA7A_0020}};
        read_expect(a, {8{a}}, 1'b0, "read A");
        write_expect(a, w, 1'b1, "write A");
        read_lines('h21, 3, 1, 1'b0, "lines B to D");
        clear_log();
        read_expect(e, {8{e}}, 1'b0, "read E");
        expect_log_size(2, "dirty eviction");
        expect_mem_op(0, 1'b1, a, w, "dirty eviction");
        expect_mem_op(1, 1'b0, e, '0, "dirty eviction");
    endtask

    task automatic clean_victim_replacement();
        logic [AW-1:0] a;
        logic [AW-1:0] e;
        a = line_address('h30, 2);
        e = line_address('h34, 2);
        read_lines('h30, 4, 2, 1'b0, "lines A to D");
        clear_log();
        read_expect(e, {8{e}}, 1'b0, "read E");
        expect_log_size(1, "clean eviction");
        expect_mem_op(0, 1'b0, e, '0, "clean eviction");
        clear_log();
        read_lines('h31, 4, 2, 1'b1, "lines B to E");
        expect_log_size(0, "hits B to E");
        read_expect(a, {8{a}}, 1'b0, "evicted A");
    endtask

    task automatic write_miss_lifecycle();
        logic [AW-1:0] f;
        logic [AW-1:0] j;
        logic [LW-1:0] w;
        f = line_address('h40, 3);
        j = line_address('h44, 3);
        w = {8{32'hF00D_0040}};
        clear_log();
        write_expect(f, w, 1'b0, "write miss F");
        expect_log_size(1, "write miss F");
        expect_mem_op(0, 1'b0, f, '0, "write miss F");
        read_expect(f, w, 1'b1, "read F");
        read_lines('h41, 3, 3, 1'b0, "lines G to I");
        clear_log();
        read_expect(j, {8{j}}, 1'b0, "read J");
        expect_log_size(2, "F eviction");
        expect_mem_op(0, 1'b1, f, w, "F eviction");
        expect_mem_op(1, 1'b0, j, '0, "F eviction");
        read_expect(f, w, 1'b0, "F from memory");
    endtask

    initial begin
        int cycles;
        error_count   = 0;
        timeout_count = 0;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        mem_address   = '0;
        mem_wdata     = '0;
        cycles        = 0;
        while (reset !== 1'b0 && cycles < 10) begin
            @(posedge clk);
            cycles++;
        end
        if (reset !== 1'b0) begin
            $display("Reset was never released");
            timeout_count++;
            end_run();
        end else begin
            reset_and_first_miss();
            repeat_read_hits();
            write_hit_then_read();
            dirty_victim_writeback();
            clean_victim_replacement();
            write_miss_lifecycle();
            end_run();
        end
    end

endmodule

`default_nettype wire

// ==== cache_top.f ====
+incdir+src
src/cache_pkg.sv
src/lru_tree.sv
src/cache_store.sv
src/cache_datapath.sv
src/cache_control.sv
src/cache_top.sv
testbench/clock_gen.sv
testbench/cache_tb.sv

// ==== Bender.yml ====
package:
  name: cache_top

sources:
  - include_dirs:
      - src
    files:
      - src/cache_pkg.sv
      - src/lru_tree.sv
      - src/cache_store.sv
      - src/cache_datapath.sv
      - src/cache_control.sv
      - src/cache_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/clock_gen.sv
      - testbench/cache_tb.sv
